/* Bender.yml */
package:
  name: axil_read_xbar

sources:
  - xbar_pkg.sv
  - rd_req_if.sv
  - skid_buffer.sv
  - addr_decoder.sv
  - ar_router.sv
  - read_return.sv
  - axil_read_xbar.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - xbar_checker.sv
      - axil_read_xbar_tb.sv

/* addr_decoder.sv */
`default_nettype none

module addr_decoder
	import xbar_pkg::*;
#(
	parameter int NS = 2,
	parameter logic [NS*AXI_AW-1:0] SLAVE_ADDR = {32'h1000_0000, 32'h0000_0000},
	parameter logic [NS*AXI_AW-1:0] SLAVE_MASK = {NS{32'hF000_0000}}
) (
	input wire i_clk,
	input wire i_reset_n,
	input wire i_valid,
	output logic o_ready,
	input wire addr_t i_addr,
	input wire prot_t i_prot,
	rd_req_if.requester req
);
	logic [NS:0] decode;

	// lowest matching base/mask pair wins
	always_comb
	begin
		decode = '0;
		for (int s = 0; s < NS; s++)
		begin
			if (decode == '0
				&& ((i_addr ^ SLAVE_ADDR[s*AXI_AW +: AXI_AW])
				& SLAVE_MASK[s*AXI_AW +: AXI_AW]) == '0)
				decode[s] = 1'b1;
		end
		// no slave claims the address
		if (decode == '0)
			decode[NS] = 1'b1;
	end

	// stall upstream while a decoded request waits for the router
	assign o_ready = !req.valid || req.accept;

	always_ff @(posedge i_clk)
	begin
		if (!i_reset_n)
			req.valid <= 1'b0;
		else if (o_ready)
			req.valid <= i_valid;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_valid && o_ready)
		begin
			req.addr <= i_addr;
			req.prot <= i_prot;
			req.sel <= decode;
		end
	end

	a_sel_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
		req.valid |-> $onehot(req.sel));

endmodule

`default_nettype wire

/* ar_router.sv */
`default_nettype none

module ar_router
	import xbar_pkg::*;
#(
	parameter int NM = 2,
	parameter int NS = 2,
	localparam int IW = (NS > 1) ? $clog2(NS) : 1
) (
	input wire i_clk,
	input wire i_reset_n,
	rd_req_if.router req [NM],
	input wire [NM-1:0] i_empty,
	input wire [NM-1:0] i_full,
	output logic [NM-1:0] o_granted,
	output logic [IW-1:0] o_grant_idx [NM],
	output logic [NM-1:0] o_err_grant,
	output logic [NS-1:0] o_m_arvalid,
	input wire [NS-1:0] i_m_arready,
	output addr_t o_m_araddr [NS],
	output prot_t o_m_arprot [NS],
	input wire [NM-1:0] i_hold_busy,
	output logic [NS-1:0] o_m_rready
);
	localparam int MW = (NM > 1) ? $clog2(NM) : 1;

	logic [NM-1:0] valid;
	logic [NS:0] sel [NM];
	addr_t addr [NM];
	prot_t prot [NM];
	logic [NM-1:0] accept;

	// one-hot grant per master, bit NS is the error target
	logic [NS:0] grant [NM];
	logic [IW-1:0] grant_idx [NM];
	logic [NS:0] grant_nxt [NM];
	logic [IW-1:0] idx_nxt [NM];

	// which master holds each slave
	logic [NM-1:0] holder [NS];
	logic [NS-1:0] slave_busy;
	logic [MW-1:0] owner [NS];
	logic [NS-1:0] ar_load;

	function automatic logic [IW-1:0] slave_index(input logic [NS-1:0] onehot);
		logic [IW-1:0] idx;
		idx = '0;
		for (int s = 0; s < NS; s++)
			if (onehot[s])
				idx = IW'(s);
		return idx;
	endfunction

	for (genvar n = 0; n < NM; n++)
	begin : g_port
		assign valid[n] = req[n].valid;
		assign sel[n] = req[n].sel;
		assign addr[n] = req[n].addr;
		assign prot[n] = req[n].prot;
		assign req[n].accept = accept[n];
		assign o_granted[n] = |grant[n];
		assign o_err_grant[n] = grant[n][NS];
		assign o_grant_idx[n] = grant_idx[n];
	end

	always_comb
	begin
		for (int s = 0; s < NS; s++)
		begin
			owner[s] = '0;
			for (int n = 0; n < NM; n++)
			begin
				holder[s][n] = grant[n][s];
				if (grant[n][s])
					owner[s] = MW'(n);
			end
			slave_busy[s] = |holder[s];
		end
	end

	// lower index masters claim a free slave first
	always_comb
	begin : arbitrate
		logic [NS-1:0] claimed;
		logic stay;
		claimed = '0;
		for (int n = 0; n < NM; n++)
		begin
			grant_nxt[n] = grant[n];
			idx_nxt[n] = grant_idx[n];
			stay = (|grant[n])
				&& (!i_empty[n] || (valid[n] && |(grant[n] & sel[n])));
			if (!stay)
			begin
				if (valid[n] && (sel[n][NS]
					|| |(sel[n][NS-1:0] & ~slave_busy & ~claimed)))
				begin
					grant_nxt[n] = sel[n];
					idx_nxt[n] = slave_index(sel[n][NS-1:0]);
					claimed = claimed | sel[n][NS-1:0];
				end
				else
					grant_nxt[n] = '0;
			end
		end
	end

	always_comb
	begin
		for (int n = 0; n < NM; n++)
		begin
			accept[n] = valid[n] && |(grant[n] & sel[n]) && !i_full[n];
			// error beats go straight into the return path
			if (grant[n][NS])
				accept[n] = accept[n] && !i_hold_busy[n];
			else if (o_m_arvalid[grant_idx[n]] && !i_m_arready[grant_idx[n]])
				accept[n] = 1'b0;
		end
	end

	always_ff @(posedge i_clk)
	begin
		for (int n = 0; n < NM; n++)
		begin
			if (!i_reset_n)
			begin
				grant[n] <= '0;
				grant_idx[n] <= '0;
			end
			else
			begin
				grant[n] <= grant_nxt[n];
				grant_idx[n] <= idx_nxt[n];
			end
		end
	end

	always_comb
	begin
		for (int s = 0; s < NS; s++)
		begin
			ar_load[s] = slave_busy[s] && accept[owner[s]];
			o_m_rready[s] = !(slave_busy[s] && i_hold_busy[owner[s]]);
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_reset_n)
			o_m_arvalid <= '0;
		else
		begin
			for (int s = 0; s < NS; s++)
				if (!o_m_arvalid[s] || i_m_arready[s])
					o_m_arvalid[s] <= ar_load[s];
		end
	end

	always_ff @(posedge i_clk)
	begin
		for (int s = 0; s < NS; s++)
		begin
			if (ar_load[s])
			begin
				o_m_araddr[s] <= addr[owner[s]];
				o_m_arprot[s] <= prot[owner[s]];
			end
		end
	end

	for (genvar s = 0; s < NS; s++)
	begin : g_check
		a_one_owner: assert property (@(posedge i_clk) disable iff (!i_reset_n)
			$onehot0(holder[s]));
	end

endmodule

`default_nettype wire

/* axil_read_xbar.f */
xbar_pkg.sv
rd_req_if.sv
skid_buffer.sv
addr_decoder.sv
ar_router.sv
read_return.sv
axil_read_xbar.sv
tb_clock_gen.sv
xbar_checker.sv
axil_read_xbar_tb.sv

/* axil_read_xbar.sv */
`default_nettype none

module axil_read_xbar
	import xbar_pkg::*;
#(
	parameter int NM = 2,
	parameter int NS = 2,
	parameter logic [NS*AXI_AW-1:0] SLAVE_ADDR = {32'h1000_0000, 32'h0000_0000},
	parameter logic [NS*AXI_AW-1:0] SLAVE_MASK = {NS{32'hF000_0000}},
	parameter int LGMAXBURST = 3
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// upstream masters
	input wire [NM-1:0] i_s_axi_arvalid,
	output wire [NM-1:0] o_s_axi_arready,
	input wire [NM*AXI_AW-1:0] i_s_axi_araddr,
	input wire [NM*3-1:0] i_s_axi_arprot,
	output wire [NM-1:0] o_s_axi_rvalid,
	input wire [NM-1:0] i_s_axi_rready,
	output wire [NM*AXI_DW-1:0] o_s_axi_rdata,
	output wire [NM*2-1:0] o_s_axi_rresp,
	// downstream slaves
	output wire [NS-1:0] o_m_axi_arvalid,
	input wire [NS-1:0] i_m_axi_arready,
	output wire [NS*AXI_AW-1:0] o_m_axi_araddr,
	output wire [NS*3-1:0] o_m_axi_arprot,
	input wire [NS-1:0] i_m_axi_rvalid,
	output wire [NS-1:0] o_m_axi_rready,
	input wire [NS*AXI_DW-1:0] i_m_axi_rdata,
	input wire [NS*2-1:0] i_m_axi_rresp
);
	localparam int IW = (NS > 1) ? $clog2(NS) : 1;
	localparam int ARW = AXI_AW + $bits(prot_t);

	logic [NM-1:0] empty;
	logic [NM-1:0] full;
	logic [NM-1:0] hold_busy;
	logic [NM-1:0] granted;
	logic [NM-1:0] err_grant;
	logic [IW-1:0] grant_idx [NM];
	addr_t m_araddr [NS];
	prot_t m_arprot [NS];
	data_t m_rdata [NS];
	resp_t m_rresp [NS];

	rd_req_if #(.NS(NS)) req_bus [NM] ();

	for (genvar s = 0; s < NS; s++)
	begin : g_slave
		assign o_m_axi_araddr[s*AXI_AW +: AXI_AW] = m_araddr[s];
		assign o_m_axi_arprot[s*3 +: 3] = m_arprot[s];
		assign m_rdata[s] = i_m_axi_rdata[s*AXI_DW +: AXI_DW];
		assign m_rresp[s] = i_m_axi_rresp[s*2 +: 2];
	end

	for (genvar g = 0; g < NM; g++)
	begin : g_master
		logic skd_valid;
		logic skd_ready;
		logic [ARW-1:0] skd_data;

		skid_buffer #(.WIDTH(ARW)) ar_skid (
			.i_clk(S_AXI_ACLK),
			.i_reset_n(S_AXI_ARESETN),
			.i_valid(i_s_axi_arvalid[g]),
			.o_ready(o_s_axi_arready[g]),
			.i_data({i_s_axi_araddr[g*AXI_AW +: AXI_AW], i_s_axi_arprot[g*3 +: 3]}),
			.o_valid(skd_valid),
			.i_ready(skd_ready),
			.o_data(skd_data)
		);

		addr_decoder #(
			.NS(NS),
			.SLAVE_ADDR(SLAVE_ADDR),
			.SLAVE_MASK(SLAVE_MASK)
		) ar_decode (
			.i_clk(S_AXI_ACLK),
			.i_reset_n(S_AXI_ARESETN),
			.i_valid(skd_valid),
			.o_ready(skd_ready),
			.i_addr(skd_data[ARW-1 -: AXI_AW]),
			.i_prot(skd_data[$bits(prot_t)-1:0]),
			.req(req_bus[g])
		);

		read_return #(.NS(NS), .LGMAXBURST(LGMAXBURST)) r_return (
			.i_clk(S_AXI_ACLK),
			.i_reset_n(S_AXI_ARESETN),
			.i_granted(granted[g]),
			.i_grant_idx(grant_idx[g]),
			.i_err_grant(err_grant[g]),
			.i_req_done(req_bus[g].valid && req_bus[g].accept),
			.i_m_rvalid(i_m_axi_rvalid),
			.i_m_rdata(m_rdata),
			.i_m_rresp(m_rresp),
			.o_s_rvalid(o_s_axi_rvalid[g]),
			.i_s_rready(i_s_axi_rready[g]),
			.o_s_rdata(o_s_axi_rdata[g*AXI_DW +: AXI_DW]),
			.o_s_rresp(o_s_axi_rresp[g*2 +: 2]),
			.o_hold_busy(hold_busy[g]),
			.o_empty(empty[g]),
			.o_full(full[g])
		);
	end

	ar_router #(.NM(NM), .NS(NS)) router (
		.i_clk(S_AXI_ACLK),
		.i_reset_n(S_AXI_ARESETN),
		.req(req_bus),
		.i_empty(empty),
		.i_full(full),
		.o_granted(granted),
		.o_grant_idx(grant_idx),
		.o_err_grant(err_grant),
		.o_m_arvalid(o_m_axi_arvalid),
		.i_m_arready(i_m_axi_arready),
		.o_m_araddr(m_araddr),
		.o_m_arprot(m_arprot),
		.i_hold_busy(hold_busy),
		.o_m_rready(o_m_axi_rready)
	);

endmodule

`default_nettype wire

/* axil_read_xbar_tb.sv */
`default_nettype none

module axil_read_xbar_tb
	import xbar_pkg::*;
;
	localparam int NM = 2;
	localparam int NS = 2;
	localparam int LGMAXBURST = 3;
	localparam logic [NS*AXI_AW-1:0] MAP_BASE = {32'h1000_0000, 32'h0000_0000};
	localparam logic [NS*AXI_AW-1:0] MAP_MASK = {NS{32'hF000_0000}};
	localparam logic [AXI_DW-1:0] SLAVE_TAG = 32'h5A00_0000;
	localparam int NUM_TESTS = 5;
	localparam int BURST_LEN = 8;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 200;

	wire S_AXI_ACLK;
	wire S_AXI_ARESETN;

	logic [NM-1:0] s_arvalid;
	logic [NM*AXI_AW-1:0] s_araddr;
	logic [NM*3-1:0] s_arprot;
	logic [NM-1:0] s_rready;
	logic [NS-1:0] m_arready;
	logic [NS-1:0] m_rvalid;
	logic [NS*AXI_DW-1:0] m_rdata;
	logic [NS*2-1:0] m_rresp;

	wire [NM-1:0] s_arready;
	wire [NM-1:0] s_rvalid;
	wire [NM*AXI_DW-1:0] s_rdata;
	wire [NM*2-1:0] s_rresp;
	wire [NS-1:0] m_arvalid;
	wire [NS*AXI_AW-1:0] m_araddr;
	wire [NS*3-1:0] m_arprot;
	wire [NS-1:0] m_rready;

	wire [NM*AXI_DW-1:0] exp_data;
	wire [NM*2-1:0] exp_resp;
	wire [NS*3-1:0] exp_arprot;
	int chk_errors;
	int chk_pending;

	logic [3:0] test_id;
	logic test_done;
	logic bp_en;
	integer seed = 32'hfadf;
	int cycle = 0;

	// lowest matching slave wins, no match is an interconnect error
	function automatic logic [AXI_DW+1:0] expected_beat(input addr_t addr);
		logic [AXI_DW+1:0] beat;
		beat = {2'b11, {AXI_DW{1'b0}}};
		for (int s = NS - 1; s >= 0; s--)
			if ((addr & MAP_MASK[s*AXI_AW +: AXI_AW]) == MAP_BASE[s*AXI_AW +: AXI_AW])
				beat = {2'b00, addr ^ (SLAVE_TAG + s)};
		return beat;
	endfunction

	// prot tagged with address bits so each read can be matched downstream
	function automatic prot_t prot_tag(input addr_t addr);
		return addr[4:2];
	endfunction

	function automatic addr_t random_addr(input int slave);
		logic [31:0] rnd;
		rnd = $random(seed);
		return {4'(slave), rnd[27:2], 2'b00};
	endfunction

	tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(3)) clock_gen (
		.o_clk(S_AXI_ACLK),
		.o_reset_n(S_AXI_ARESETN)
	);

	axil_read_xbar #(
		.NM(NM),
		.NS(NS),
		.SLAVE_ADDR(MAP_BASE),
		.SLAVE_MASK(MAP_MASK),
		.LGMAXBURST(LGMAXBURST)
	) axil_read_xbar_inst (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_s_axi_arvalid(s_arvalid),
		.o_s_axi_arready(s_arready),
		.i_s_axi_araddr(s_araddr),
		.i_s_axi_arprot(s_arprot),
		.o_s_axi_rvalid(s_rvalid),
		.i_s_axi_rready(s_rready),
		.o_s_axi_rdata(s_rdata),
		.o_s_axi_rresp(s_rresp),
		.o_m_axi_arvalid(m_arvalid),
		.i_m_axi_arready(m_arready),
		.o_m_axi_araddr(m_araddr),
		.o_m_axi_arprot(m_arprot),
		.i_m_axi_rvalid(m_rvalid),
		.o_m_axi_rready(m_rready),
		.i_m_axi_rdata(m_rdata),
		.i_m_axi_rresp(m_rresp)
	);

	xbar_checker #(.NM(NM), .NS(NS), .NUM_TESTS(NUM_TESTS)) checker_inst (
		.i_clk(S_AXI_ACLK),
		.i_reset_n(S_AXI_ARESETN),
		.i_test(test_id),
		.i_test_done(test_done),
		.i_s_arvalid(s_arvalid),
		.i_s_arready(s_arready),
		.i_s_rvalid(s_rvalid),
		.i_s_rready(s_rready),
		.i_s_rdata(s_rdata),
		.i_s_rresp(s_rresp),
		.i_exp_data(exp_data),
		.i_exp_resp(exp_resp),
		.i_m_arvalid(m_arvalid),
		.i_m_arready(m_arready),
		.i_m_arprot(m_arprot),
		.i_exp_arprot(exp_arprot),
		.i_m_rready(m_rready),
		.o_errors(chk_errors),
		.o_pending(chk_pending)
	);

	// expected beat for whatever address each master presents
	for (genvar m = 0; m < NM; m++)
	begin : g_expect
		assign {exp_resp[m*2 +: 2], exp_data[m*AXI_DW +: AXI_DW]} =
			expected_beat(s_araddr[m*AXI_AW +: AXI_AW]);
	end

	// prot each slave should see with the address it gets
	for (genvar s = 0; s < NS; s++)
	begin : g_expect_prot
		assign exp_arprot[s*3 +: 3] = prot_tag(m_araddr[s*AXI_AW +: AXI_AW]);
	end

	always @(posedge S_AXI_ACLK)
		cycle <= cycle + 1;

	// slave models, in-order replies after 1 to 4 cycles
	for (genvar s = 0; s < NS; s++)
	begin : g_slave_model
		addr_t q_addr [$];
		int q_due [$];

		always @(posedge S_AXI_ACLK)
		begin
			if (!S_AXI_ARESETN)
			begin
				m_arready[s] <= 1'b1;
				m_rvalid[s] <= 1'b0;
				q_addr.delete();
				q_due.delete();
			end
			else
			begin
				if (m_arvalid[s] && m_arready[s])
				begin
					q_addr.push_back(m_araddr[s*AXI_AW +: AXI_AW]);
					q_due.push_back(cycle + 1 + ($random(seed) & 3));
				end
				m_arready[s] <= ($random(seed) & 3) != 0;
				if (!m_rvalid[s] || m_rready[s])
				begin
					if (q_addr.size() > 0 && q_due[0] <= cycle)
					begin
						m_rvalid[s] <= 1'b1;
						m_rdata[s*AXI_DW +: AXI_DW] <= q_addr.pop_front() ^ (SLAVE_TAG + s);
						m_rresp[s*2 +: 2] <= 2'b00;
						void'(q_due.pop_front());
					end
					else
						m_rvalid[s] <= 1'b0;
				end
			end
		end
	end

	// master side RREADY, random stalls only when enabled
	always @(posedge S_AXI_ACLK)
	begin
		for (int m = 0; m < NM; m++)
			s_rready[m] <= !bp_en || (($random(seed) & 3) != 0);
	end

	task automatic issue_read(input int m, input addr_t addr);
		s_arvalid[m] <= 1'b1;
		s_araddr[m*AXI_AW +: AXI_AW] <= addr;
		s_arprot[m*3 +: 3] <= prot_tag(addr);
		@(posedge S_AXI_ACLK);
		while (!s_arready[m])
			@(posedge S_AXI_ACLK);
		s_arvalid[m] <= 1'b0;
	endtask

	task automatic burst(input int m, input int slave, input int count);
		int gap;
		for (int i = 0; i < count; i++)
		begin
			issue_read(m, random_addr(slave));
			gap = $random(seed) & 3;
			repeat (gap) @(posedge S_AXI_ACLK);
		end
	endtask

	task automatic wait_drain();
		@(posedge S_AXI_ACLK);
		while (chk_pending != 0)
			@(posedge S_AXI_ACLK);
	endtask

	task automatic finish_test();
		test_done <= 1'b1;
		@(posedge S_AXI_ACLK);
		test_done <= 1'b0;
	endtask

	initial
	begin
		s_arvalid = '0;
		s_araddr = '0;
		s_arprot = '0;
		s_rready = '1;
		m_arready = '1;
		m_rvalid = '0;
		m_rdata = '0;
		m_rresp = '0;
		test_id = 4'd0;
		test_done = 1'b0;
		bp_en = 1'b0;
		wait (S_AXI_ARESETN === 1'b1);
		@(posedge S_AXI_ACLK);

		test_id <= 4'd1;
		repeat (10) @(posedge S_AXI_ACLK);
		finish_test();

		// master 0 alternates between both slaves
		test_id <= 4'd2;
		issue_read(0, 32'h0000_0100);
		issue_read(0, 32'h1000_0200);
		issue_read(0, 32'h0000_0abc);
		issue_read(0, 32'h1fff_fff0);
		wait_drain();
		finish_test();

		test_id <= 4'd3;
		issue_read(0, 32'h3000_0000);
		issue_read(1, 32'hf000_1234);
		issue_read(0, 32'h2000_0040);
		wait_drain();
		finish_test();

		// both masters fight for slave 0
		test_id <= 4'd4;
		fork
			burst(0, 0, BURST_LEN);
			burst(1, 0, BURST_LEN);
		join
		wait_drain();
		finish_test();

		test_id <= 4'd5;
		bp_en <= 1'b1;
		fork
			burst(0, 0, BURST_LEN);
			burst(1, 1, BURST_LEN);
		join
		wait_drain();
		bp_en <= 1'b0;
		finish_test();

		@(posedge S_AXI_ACLK);
		if (chk_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge S_AXI_ACLK);
		$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* rd_req_if.sv */
`default_nettype none

interface rd_req_if
	import xbar_pkg::*;
#(
	parameter int NS = 2
);
	// decoded read request toward the router
	logic valid;
	addr_t addr;
	prot_t prot;
	// one-hot target with the error target in bit NS
	logic [NS:0] sel;
	// request moves when valid and accept are both high
	logic accept;

	modport requester (
		output valid,
		output addr,
		output prot,
		output sel,
		input accept
	);

	modport router (
		input valid,
		input addr,
		input prot,
		input sel,
		output accept
	);

endinterface

`default_nettype wire

/* read_return.sv */
`default_nettype none

module read_return
	import xbar_pkg::*;
#(
	parameter int NS = 2,
	parameter int LGMAXBURST = 3,
	localparam int IW = (NS > 1) ? $clog2(NS) : 1
) (
	input wire i_clk,
	input wire i_reset_n,
	input wire i_granted,
	input wire [IW-1:0] i_grant_idx,
	input wire i_err_grant,
	input wire i_req_done,
	input wire [NS-1:0] i_m_rvalid,
	input wire data_t i_m_rdata [NS],
	input wire resp_t i_m_rresp [NS],
	output logic o_s_rvalid,
	input wire i_s_rready,
	output data_t o_s_rdata,
	output resp_t o_s_rresp,
	output logic o_hold_busy,
	output logic o_empty,
	output logic o_full
);
	logic in_valid;
	data_t in_data;
	resp_t in_resp;
	logic stall;
	data_t hold_data;
	resp_t hold_resp;
	logic [LGMAXBURST-1:0] pending;

	// slave beats only count while RREADY is up, i.e. hold is empty
	always_comb
	begin
		if (i_err_grant)
		begin
			in_valid = i_req_done;
			in_data = '0;
			in_resp = RESP_INTERCONNECT_ERROR;
		end
		else
		begin
			in_valid = i_granted && i_m_rvalid[i_grant_idx] && !o_hold_busy;
			in_data = i_m_rdata[i_grant_idx];
			in_resp = i_m_rresp[i_grant_idx];
		end
	end

	assign stall = o_s_rvalid && !i_s_rready;

	always_ff @(posedge i_clk)
	begin
		if (!i_reset_n)
		begin
			o_s_rvalid <= 1'b0;
			o_hold_busy <= 1'b0;
		end
		else if (!stall)
		begin
			o_s_rvalid <= o_hold_busy || in_valid;
			o_hold_busy <= 1'b0;
		end
		else if (in_valid)
			o_hold_busy <= 1'b1;
	end

	// hold drains ahead of any newer beat
	always_ff @(posedge i_clk)
	begin
		if (stall && in_valid)
		begin
			hold_data <= in_data;
			hold_resp <= in_resp;
		end
		if (!stall && o_hold_busy)
		begin
			o_s_rdata <= hold_data;
			o_s_rresp <= hold_resp;
		end
		else if (!stall && in_valid)
		begin
			o_s_rdata <= in_data;
			o_s_rresp <= in_resp;
		end
	end

	// accepted requests minus delivered beats
	always_ff @(posedge i_clk)
	begin
		if (!i_reset_n)
			pending <= '0;
		else
		begin
			case ({i_req_done, o_s_rvalid && i_s_rready})
			2'b10: pending <= pending + 1'b1;
			2'b01: pending <= pending - 1'b1;
			default: pending <= pending;
			endcase
		end
	end

	assign o_empty = (pending == '0);
	assign o_full = &pending;

	a_r_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
		stall |=> o_s_rvalid && $stable(o_s_rdata) && $stable(o_s_rresp));

endmodule

`default_nettype wire

/* skid_buffer.sv */
`default_nettype none

module skid_buffer #(
	parameter int WIDTH = 8
) (
	input wire i_clk,
	input wire i_reset_n,
	input wire i_valid,
	output logic o_ready,
	input wire [WIDTH-1:0] i_data,
	output logic o_valid,
	input wire i_ready,
	output logic [WIDTH-1:0] o_data
);
	logic r_valid;
	logic [WIDTH-1:0] r_data;

	// park one item when the consumer stalls
	always_ff @(posedge i_clk)
	begin
		if (!i_reset_n)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_valid && o_ready)
			r_data <= i_data;
	end

	// ready comes straight from a flop
	assign o_ready = !r_valid;

	// empty buffer passes data through
	assign o_valid = i_valid || r_valid;
	assign o_data = r_valid ? r_data : i_data;

	a_hold_data: assert property (@(posedge i_clk) disable iff (!i_reset_n)
		o_valid && !i_ready |=> $stable(o_data));

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic o_clk,
	output logic o_reset_n
);
	initial
	begin
		o_clk = 1'b0;
		forever
			#(PERIOD / 2) o_clk = ~o_clk;
	end

	// reset held low for the first few edges
	initial
	begin
		o_reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_reset_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* xbar_checker.sv */
`default_nettype none

module xbar_checker
	import xbar_pkg::*;
#(
	parameter int NM = 2,
	parameter int NS = 2,
	parameter int NUM_TESTS = 5
) (
	input wire i_clk,
	input wire i_reset_n,
	input wire [3:0] i_test,
	input wire i_test_done,
	input wire [NM-1:0] i_s_arvalid,
	input wire [NM-1:0] i_s_arready,
	input wire [NM-1:0] i_s_rvalid,
	input wire [NM-1:0] i_s_rready,
	input wire [NM*AXI_DW-1:0] i_s_rdata,
	input wire [NM*2-1:0] i_s_rresp,
	input wire [NM*AXI_DW-1:0] i_exp_data,
	input wire [NM*2-1:0] i_exp_resp,
	input wire [NS-1:0] i_m_arvalid,
	input wire [NS-1:0] i_m_arready,
	input wire [NS*3-1:0] i_m_arprot,
	input wire [NS*3-1:0] i_exp_arprot,
	input wire [NS-1:0] i_m_rready,
	output int o_errors,
	output int o_pending
);
	// expected beats per master, in request order
	logic [AXI_DW+1:0] exp_q [NM][$];
	logic [AXI_DW+1:0] head;
	int errors = 0;
	int test_errors = 0;
	int test_beats = 0;
	int beats = 0;
	int tests_failed = 0;
	int waiting;

	task automatic flag_mismatch(input string name, input logic [AXI_DW-1:0] exp_val,
		input logic [AXI_DW-1:0] got_val);
		$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp_val, got_val);
		errors++;
		test_errors++;
	endtask

	always @(posedge i_clk)
	begin
		if (!i_reset_n)
		begin
			for (int m = 0; m < NM; m++)
				exp_q[m].delete();
		end
		else
		begin
			for (int m = 0; m < NM; m++)
			begin
				if (i_s_arvalid[m] && i_s_arready[m])
					exp_q[m].push_back({i_exp_resp[m*2 +: 2], i_exp_data[m*AXI_DW +: AXI_DW]});
				if (i_s_rvalid[m] && i_s_rready[m])
				begin
					if (exp_q[m].size() == 0)
					begin
						$display("ERROR at %0t: master %0d got a read beat it never asked for",
							$time, m);
						errors++;
						test_errors++;
					end
					else
					begin
						head = exp_q[m].pop_front();
						test_beats++;
						beats++;
						if (i_s_rdata[m*AXI_DW +: AXI_DW] !== head[AXI_DW-1:0])
							flag_mismatch($sformatf("o_s_axi_rdata[%0d]", m),
								head[AXI_DW-1:0], i_s_rdata[m*AXI_DW +: AXI_DW]);
						if (i_s_rresp[m*2 +: 2] !== head[AXI_DW +: 2])
							flag_mismatch($sformatf("o_s_axi_rresp[%0d]", m),
								head[AXI_DW +: 2], i_s_rresp[m*2 +: 2]);
					end
				end
			end

			// prot must travel with its address to the slave
			for (int s = 0; s < NS; s++)
			begin
				if (i_m_arvalid[s] && i_m_arready[s]
					&& i_m_arprot[s*3 +: 3] !== i_exp_arprot[s*3 +: 3])
					flag_mismatch($sformatf("o_m_axi_arprot[%0d]", s),
						i_exp_arprot[s*3 +: 3], i_m_arprot[s*3 +: 3]);
			end

			// idle after reset
			if (i_test == 4'd1)
			begin
				if (i_s_rvalid !== '0)
					flag_mismatch("o_s_axi_rvalid", '0, i_s_rvalid);
				if (i_m_arvalid !== '0)
					flag_mismatch("o_m_axi_arvalid", '0, i_m_arvalid);
				if (i_s_arready !== '1)
					flag_mismatch("o_s_axi_arready", {NM{1'b1}}, i_s_arready);
				if (i_m_rready !== '1)
					flag_mismatch("o_m_axi_rready", {NS{1'b1}}, i_m_rready);
			end
			// unmapped reads must stay inside the crossbar
			if (i_test == 4'd3 && i_m_arvalid !== '0)
				flag_mismatch("o_m_axi_arvalid", '0, i_m_arvalid);

			if (i_test_done)
			begin
				for (int m = 0; m < NM; m++)
				begin
					if (exp_q[m].size() != 0)
					begin
						$display("ERROR at %0t: master %0d still waits for %0d read beats",
							$time, m, exp_q[m].size());
						errors++;
						test_errors++;
					end
				end
				if (test_errors != 0)
					tests_failed++;
				$display("test %0d %s: %0d beats checked, %0d errors", i_test,
					(test_errors == 0) ? "passed" : "FAILED", test_beats, test_errors);
				if (i_test == NUM_TESTS)
					$display("summary: %0d of %0d tests passed, %0d beats, %0d errors",
						NUM_TESTS - tests_failed, NUM_TESTS, beats, errors);
				test_errors = 0;
				test_beats = 0;
			end
		end

		waiting = 0;
		for (int m = 0; m < NM; m++)
			waiting += exp_q[m].size();
		o_pending <= waiting;
		o_errors <= errors;
	end

endmodule

`default_nettype wire

/* xbar_pkg.sv */
`default_nettype none

package xbar_pkg;

	// bus widths
	localparam int AXI_AW = 32;
	localparam int AXI_DW = 32;

	typedef logic [AXI_AW-1:0] addr_t;
	typedef logic [AXI_DW-1:0] data_t;
	typedef logic [2:0] prot_t;
	typedef logic [1:0] resp_t;

	// read response codes
	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_INTERCONNECT_ERROR = 2'b11;

endpackage

`default_nettype wire
